//--- operandUnit_consts.svh
// Width and register-count macros for the operand unit, included by the package and the RTL
`ifndef OPERANDUNIT_CONSTS_SVH
`define OPERANDUNIT_CONSTS_SVH

// ====================
// Data path
// ====================

// Width of every register value and of the ALU
`define DATA_W 32

// Immediate field width in the instruction, sign-extended to DATA_W by decode
`define IMM_W 16

// ====================
// Register numbering
// ====================

// Architectural register numbers are 0 to 31
`define AREG_W 5

// Physical numbers need one more bit for the banked stack pointers
`define PREG_W 6

// 32 architectural slots followed by one stack pointer per operating mode
`define NUM_PREGS 36

// Architectural number that selects the banked stack pointer
`define SP_REG 31

`endif

//--- operandPkg.sv
// Shared enums and packed structs of the operand unit, imported by every RTL module
`default_nettype none

`include "operandUnit_consts.svh"

package operandPkg;

	// ====================
	// Enumerations
	// ====================

	// Operating mode, also the bank index of the stack pointer
	typedef enum logic [1:0] {
		USER,
		SUPER,
		HYPER,
		MACHINE
	} opModeT;

	// Instruction opcodes, the last three carry an immediate b operand
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_ADDI = 4'd4,
		OP_LDI  = 4'd5,
		OP_RTD  = 4'd6
	} opcodeT;

	// States of the writeback and host handshake FSM
	typedef enum logic [1:0] {
		IDLE,
		WORK,
		HOLD
	} resultStateT;

	// ====================
	// Structures
	// ====================

	// Instruction as the host offers it, architectural register numbers
	typedef struct packed {
		opcodeT opcode;
		logic [`AREG_W-1:0] rd;
		logic [`AREG_W-1:0] ra;
		logic [`AREG_W-1:0] rb;
		logic rbNeg;
		logic [`IMM_W-1:0] imm;
	} instrT;

	// One host request, the mode selects the stack pointer bank
	typedef struct packed {
		instrT instr;
		opModeT mode;
	} requestT;

	// Decode output with physical register numbers and operand flags
	typedef struct packed {
		opcodeT opcode;
		logic [`PREG_W-1:0] pRd;
		logic [`PREG_W-1:0] pRa;
		logic [`PREG_W-1:0] pRb;
		logic rbZero;
		logic rbNeg;
		logic useImm;
		logic [`DATA_W-1:0] imm;
	} decodedT;

	// ALU value on its way to the register file and the host
	typedef struct packed {
		logic [`DATA_W-1:0] value;
		logic [`PREG_W-1:0] pRd;
	} resultT;

endpackage

`default_nettype wire

//--- operandDecode.sv
// Request capture and operand decode stage, turns an instruction and mode into physical registers
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandDecode (
	input wire clk,
	input wire rst,
	input wire req,
	input wire busy,
	input wire operandPkg::requestT request,
	output logic decValid,
	output operandPkg::decodedT decoded
);

	import operandPkg::*;

	// Physical number of the first banked stack pointer
	localparam int SpBase = 1 << `AREG_W;

	logic reqPrev;
	logic pending;
	logic accept;
	logic isImm;
	logic [`AREG_W-1:0] aRd;
	logic [`AREG_W-1:0] aRa;
	requestT held;
	decodedT decNext;

	// Register 31 lands in the bank of the current mode, every other number maps straight
	function automatic logic [`PREG_W-1:0] mapReg(input logic [`AREG_W-1:0] aReg,
		input opModeT mode);
		if (aReg == `AREG_W'(`SP_REG))
			return `PREG_W'(SpBase + int'(mode));
		else
			return `PREG_W'(aReg);
	endfunction

	// Only a fresh rising req is taken, and only while the result side is idle
	assign accept = req && !reqPrev && !busy && !pending;

	// ====================
	// Operand rules
	// ====================

	always_comb
	begin
		isImm = (held.instr.opcode == OP_ADDI) || (held.instr.opcode == OP_LDI) ||
			(held.instr.opcode == OP_RTD);
		// RTD both reads and writes the stack pointer of the current mode
		aRd = (held.instr.opcode == OP_RTD) ? `AREG_W'(`SP_REG) : held.instr.rd;
		aRa = (held.instr.opcode == OP_RTD) ? `AREG_W'(`SP_REG) : held.instr.ra;
		decNext.opcode = held.instr.opcode;
		decNext.pRd = mapReg(aRd, held.mode);
		decNext.pRa = mapReg(aRa, held.mode);
		// Immediate forms point b at register 0 so the rb field is ignored
		decNext.pRb = isImm ? '0 : mapReg(held.instr.rb, held.mode);
		decNext.rbZero = (decNext.pRb == '0);
		decNext.rbNeg = held.instr.rbNeg;
		decNext.useImm = isImm;
		decNext.imm = {{(`DATA_W-`IMM_W){held.instr.imm[`IMM_W-1]}}, held.instr.imm};
	end

	// ====================
	// Stage registers
	// ====================

	// Control flow is accept, then one cycle later the decoded strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			reqPrev <= 1'b0;
			pending <= 1'b0;
			decValid <= 1'b0;
		end
		else
		begin
			reqPrev <= req;
			pending <= accept;
			decValid <= pending;
		end
	end

	// The request is captured on acceptance and decoded from the held copy
	always_ff @(posedge clk)
	begin
		if (accept)
			held <= request;
		if (pending)
			decoded <= decNext;
	end

	// Only one instruction is ever in flight, so the strobe is a single pulse
	assert property (@(posedge clk) disable iff (rst) decValid |=> !decValid)
		else $error("decValid high on two cycles in a row");

endmodule

`default_nettype wire

//--- operandExecute.sv
// Execute stage holding the banked register file and the ALU, fed by decode and written by result
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandExecute (
	input wire clk,
	input wire rst,
	input wire decValid,
	input wire operandPkg::decodedT decoded,
	input wire wrEn,
	input wire [`PREG_W-1:0] wrReg,
	input wire [`DATA_W-1:0] wrData,
	output logic exValid,
	output operandPkg::resultT exResult
);

	import operandPkg::*;

	// 32 architectural registers plus the four banked stack pointers
	logic [`DATA_W-1:0] regFile [`NUM_PREGS];

	logic [`DATA_W-1:0] aVal;
	logic [`DATA_W-1:0] bReg;
	logic [`DATA_W-1:0] bVal;
	logic [`DATA_W-1:0] aluOut;

	// ====================
	// Register file
	// ====================

	// Every register comes out of reset at zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `NUM_PREGS; i++)
				regFile[i] <= '0;
		end
		// Register 0 is hardwired, so writes to it go nowhere
		else if (wrEn && (wrReg != '0))
			regFile[wrReg] <= wrData;
	end

	// ====================
	// Operand select and ALU
	// ====================

	always_comb
	begin
		// Register 0 reads as zero whatever the array holds
		aVal = (decoded.pRa == '0) ? '0 : regFile[decoded.pRa];
		bReg = decoded.rbZero ? '0 : regFile[decoded.pRb];
		bVal = decoded.useImm ? decoded.imm : bReg;
		// The negate bit complements b after the select
		if (decoded.rbNeg)
			bVal = ~bVal;
		case (decoded.opcode)
			OP_ADD,
			OP_ADDI,
			OP_RTD:
				aluOut = aVal + bVal;
			OP_SUB:
				aluOut = aVal - bVal;
			OP_AND:
				aluOut = aVal & bVal;
			OP_OR:
				aluOut = aVal | bVal;
			// Load immediate takes the sign-extended field as is
			OP_LDI:
				aluOut = decoded.imm;
			default:
				aluOut = '0;
		endcase
	end

	// ====================
	// Stage register
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
			exValid <= 1'b0;
		else
			exValid <= decValid;
	end

	// Value and destination travel together to the result stage
	always_ff @(posedge clk)
	begin
		if (decValid)
		begin
			exResult.value <= aluOut;
			exResult.pRd <= decoded.pRd;
		end
	end

	// Decode must never hand over a number outside the physical file
	assert property (@(posedge clk) disable iff (rst)
		decValid |-> (decoded.pRa < `NUM_PREGS) && (decoded.pRb < `NUM_PREGS) &&
		(decoded.pRd < `NUM_PREGS))
		else $error("physical operand out of range, pRa %0h pRb %0h pRd %0h",
			decoded.pRa, decoded.pRb, decoded.pRd);

endmodule

`default_nettype wire

//--- operandResult.sv
// Writeback and host handshake stage, drives the register write port, ack and result
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandResult (
	input wire clk,
	input wire rst,
	input wire exValid,
	input wire operandPkg::resultT exResult,
	input wire req,
	output logic wrEn,
	output logic [`PREG_W-1:0] wrReg,
	output logic [`DATA_W-1:0] wrData,
	output logic ack,
	output logic [`DATA_W-1:0] result,
	output logic busy
);

	import operandPkg::*;

	resultStateT state;

	// Decode accepts on the same edge that moves this FSM out of IDLE
	assign busy = (state != IDLE);

	// ====================
	// Handshake FSM
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			ack <= 1'b0;
			wrEn <= 1'b0;
		end
		else
		begin
			// The write strobe lasts one cycle
			wrEn <= 1'b0;
			case (state)
				IDLE:
					if (req)
						state <= WORK;
				WORK:
					if (exValid)
					begin
						wrEn <= 1'b1;
						ack <= 1'b1;
						state <= HOLD;
					end
				// Ack stays up as long as the host holds req
				HOLD:
					if (!req)
					begin
						ack <= 1'b0;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Write port and host result load together when the ALU value arrives
	always_ff @(posedge clk)
	begin
		if ((state == WORK) && exValid)
		begin
			wrReg <= exResult.pRd;
			wrData <= exResult.value;
			result <= exResult.value;
		end
	end

	// Four-phase rule, ack may only drop after the host lets go of req
	assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
		else $error("ack fell while req was high");

	// An execute strobe outside WORK means decode accepted behind our back
	assert property (@(posedge clk) disable iff (rst) exValid |-> (state == WORK))
		else $error("exValid arrived in state %s", state.name());

endmodule

`default_nettype wire

//--- operandUnit.sv
// Top level of the operand unit, joins decode, execute and result behind the host req/ack port
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandUnit (
	input wire clk,
	input wire rst,
	input wire req,
	input wire operandPkg::requestT request,
	output logic ack,
	output logic [`DATA_W-1:0] result
);

	import operandPkg::*;

	// ====================
	// Stage connections
	// ====================

	logic decValid;
	decodedT decoded;
	logic exValid;
	resultT exResult;
	logic busy;

	// Register file write port, driven by result and owned by execute
	logic wrEn;
	logic [`PREG_W-1:0] wrReg;
	logic [`DATA_W-1:0] wrData;

	// Capture and decode of one host request
	operandDecode decodeStage (
		.clk(clk),
		.rst(rst),
		.req(req),
		.busy(busy),
		.request(request),
		.decValid(decValid),
		.decoded(decoded)
	);

	// Register read and ALU
	operandExecute executeStage (
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.decoded(decoded),
		.wrEn(wrEn),
		.wrReg(wrReg),
		.wrData(wrData),
		.exValid(exValid),
		.exResult(exResult)
	);

	// Writeback and handshake back to the host
	operandResult resultStage (
		.clk(clk),
		.rst(rst),
		.exValid(exValid),
		.exResult(exResult),
		.req(req),
		.wrEn(wrEn),
		.wrReg(wrReg),
		.wrData(wrData),
		.ack(ack),
		.result(result),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- operandChecker.sv
// Testbench monitor on the operand unit host port, compares results and checks the req/ack rules
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandChecker (
	input wire clk,
	input wire rst,
	input wire req,
	input wire ack,
	input wire [`DATA_W-1:0] result,
	input wire [`DATA_W-1:0] expected,
	input wire [31:0] caseIndex,
	output int errorCount,
	output int resultCount
);

	// Port values as seen at the previous rising edge
	logic reqPrev;
	logic ackPrev;
	logic rstPrev;
	logic [`DATA_W-1:0] resultPrev;

	// Inputs change 1 ns after an edge, so the edge sees the settled values of the cycle
	always @(posedge clk)
	begin
		if (rst)
		begin
			errorCount = 0;
			resultCount = 0;
			rstPrev = 1'b1;
		end
		else
		begin
			// ====================
			// Protocol rules
			// ====================

			// The first cycle out of reset must show ack low
			if (rstPrev && ack)
			begin
				$display("Error: ack was high on the first cycle after reset");
				errorCount++;
			end
			// A rising ack needs req to have been high on the edge that raised it
			if (ack && !ackPrev && !reqPrev)
			begin
				$display("Error: ack rose while req was low, case %0d", caseIndex);
				errorCount++;
			end
			// Ack may only drop on an edge that saw req low
			if (ackPrev && !ack && reqPrev)
			begin
				$display("Error: ack fell while req was still high, case %0d", caseIndex);
				errorCount++;
			end
			// While the host holds req the result must not move
			if (ack && ackPrev && (result !== resultPrev))
			begin
				$display("[FAIL] case %0d result changed during hold: got %08h expected %08h",
					caseIndex, result, resultPrev);
				errorCount++;
			end

			// ====================
			// Result compare
			// ====================

			if (ack && !ackPrev)
			begin
				resultCount++;
				if (result !== expected)
				begin
					$display("[FAIL] case %0d result: got %08h expected %08h",
						caseIndex, result, expected);
					errorCount++;
				end
			end
			rstPrev = 1'b0;
		end
		reqPrev = req;
		ackPrev = ack;
		resultPrev = result;
	end

endmodule

`default_nettype wire

//--- operandUnit_tb.sv
// Testbench for the operand unit, plays the case file through the four-phase req/ack port
`timescale 1ns/1ps
`default_nettype none

`include "operandUnit_consts.svh"

module operandUnit_tb;

	import operandPkg::*;

	// Half of the 4 ns clock period
	localparam int ClkHalf = 2;
	// Inputs move this long after a rising edge
	localparam int DriveDelay = 1;
	localparam int ResetCycles = 4;

	logic clk;
	logic rst;
	logic req;
	requestT request;
	logic ack;
	logic [`DATA_W-1:0] result;

	// Expected value and case number handed to the monitor
	logic [`DATA_W-1:0] expected;
	logic [31:0] caseIndex;
	int errorCount;
	int resultCount;
	int seqErrors;

	requestT caseReq[$];
	logic [`DATA_W-1:0] caseExp[$];

	int cycleCount = 0;
	int cycleLimit = 0;

	always #(ClkHalf) clk = ~clk;

	operandUnit UUT (
		.clk(clk),
		.rst(rst),
		.req(req),
		.request(request),
		.ack(ack),
		.result(result)
	);

	operandChecker resultCheck (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.result(result),
		.expected(expected),
		.caseIndex(caseIndex),
		.errorCount(errorCount),
		.resultCount(resultCount)
	);

	// ====================
	// Timeout
	// ====================

	// About 8 cycles per case are needed, so 12 per case leaves room
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if ((cycleLimit > 0) && (cycleCount >= cycleLimit))
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	// Reads every case line into the queues, lines starting with # are skipped
	task automatic loadCases();
		int fd;
		int n;
		string line;
		logic [31:0] fMode, fOp, fRd, fRa, fRb, fNeg, fImm, fExp;
		requestT rq;
		fd = $fopen("operandUnit_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Error: could not open operandUnit_cases.txt");
			seqErrors++;
			return;
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h",
				fMode, fOp, fRd, fRa, fRb, fNeg, fImm, fExp);
			if (n != 8)
				continue;
			rq = '0;
			rq.mode = opModeT'(fMode[1:0]);
			rq.instr.opcode = opcodeT'(fOp[3:0]);
			rq.instr.rd = fRd[`AREG_W-1:0];
			rq.instr.ra = fRa[`AREG_W-1:0];
			rq.instr.rb = fRb[`AREG_W-1:0];
			rq.instr.rbNeg = fNeg[0];
			rq.instr.imm = fImm[`IMM_W-1:0];
			caseReq.push_back(rq);
			caseExp.push_back(fExp);
		end
		$fclose(fd);
	endtask

	// One full four-phase exchange, entered and left 1 ns after a rising edge
	task automatic runCase(input int idx, input int holdExtra);
		request = caseReq[idx];
		expected = caseExp[idx];
		caseIndex = 32'(idx);
		req = 1'b1;
		do
		begin
			@(posedge clk);
			#(DriveDelay);
		end
		while (!ack);
		// Extra hold cycles exercise back-pressure on the result
		repeat (holdExtra)
		begin
			@(posedge clk);
			#(DriveDelay);
		end
		req = 1'b0;
		do
		begin
			@(posedge clk);
			#(DriveDelay);
		end
		while (ack);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		request = '0;
		expected = '0;
		caseIndex = '0;
		seqErrors = 0;
		loadCases();
		cycleLimit = 12 * caseReq.size() + 50;
		repeat (ResetCycles) @(posedge clk);
		#(DriveDelay);
		rst = 1'b0;
		for (int i = 0; i < caseReq.size(); i++)
			runCase(i, i % 3);
		@(posedge clk);
		#(DriveDelay);
		if (caseReq.size() == 0)
		begin
			$display("Error: the case file held no usable case");
			seqErrors++;
		end
		if (resultCount != caseReq.size())
		begin
			$display("Error: %0d results came back for %0d cases", resultCount, caseReq.size());
			seqErrors++;
		end
		$display("Errors: %0d from the monitor, %0d from the sequence, %0d of %0d results checked",
			errorCount, seqErrors, resultCount, caseReq.size());
		if ((errorCount == 0) && (seqErrors == 0))
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- operandUnit.f
+incdir+.
operandPkg.sv
operandDecode.sv
operandExecute.sv
operandResult.sv
operandUnit.sv
operandChecker.sv
operandUnit_tb.sv

//--- run.sh
#!/bin/sh
# Builds the operand unit testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module operandUnit_tb \
	-f operandUnit.f \
	-o simOperandUnit

./obj_dir/simOperandUnit | tee sim.log

if grep -q "Testbench passed" sim.log
then
	echo "Simulation run ok"
else
	echo "Simulation run not ok"
	exit 1
fi

//--- operandUnit_cases.txt
# Operand unit cases, one per line, every field in hex
# mode opcode rd ra rb rbNeg imm expected
0 0 03 01 02 0 0000 00000000
0 5 01 00 00 0 0005 00000005
0 5 02 00 00 0 fffd fffffffd
0 5 03 00 00 0 1234 00001234
0 5 04 00 00 0 00f0 000000f0
0 0 05 01 02 0 0000 00000002
0 1 06 01 02 0 0000 00000008
0 2 07 03 04 0 0000 00000030
0 3 08 03 04 0 0000 000012f4
0 5 00 00 00 0 7777 00007777
0 0 09 00 01 0 0000 00000005
0 0 09 01 00 0 0000 00000005
0 4 0a 01 02 0 0010 00000015
0 4 0b 03 09 0 ffff 00001233
0 0 0c 06 01 1 0000 00000002
0 0 0d 03 04 1 0000 00001143
0 1 0e 08 07 0 0000 000012c4
0 5 1f 00 00 0 0100 00000100
1 5 1f 00 00 0 0200 00000200
2 5 1f 00 00 0 0300 00000300
3 5 1f 00 00 0 0400 00000400
0 6 00 00 00 0 0008 00000108
1 6 00 00 00 0 0010 00000210
2 6 00 00 00 0 fffc 000002fc
3 6 00 00 00 0 0001 00000401
0 0 0f 1f 00 0 0000 00000108
3 0 10 1f 1f 0 0000 00000802
1 3 11 1f 01 0 0000 00000215
2 0 12 01 02 0 0000 00000002
